/* hw/har_tnn_params.svh */
`ifndef HAR_TNN_PARAMS_SVH
`define HAR_TNN_PARAMS_SVH

// ##############################
// network sizes
// ##############################

`define HAR_FEAT_CNT    12
`define HAR_FEAT_BITS   4
`define HAR_HIDDEN_CNT  40
`define HAR_CLASS_CNT   6

// ##############################
// derived widths
// ##############################

`define HAR_CNT_BITS    4 // counts accepted features, 0 to 11.
`define HAR_SUM_BITS    8 // twelve 4-bit features add up to at most 180.
`define HAR_SCORE_BITS  7 // twice a 40-bit popcount plus a bias below 8.
`define HAR_CLASS_BITS  3

`endif

/* hw/har_tnn_pkg.sv */
`default_nettype none

`include "har_tnn_params.svh"

package har_tnn_pkg;

    typedef enum logic [1:0] {
        LOAD,
        HIDDEN,
        RESULT
    } ctrl_state_e;

    typedef logic [`HAR_CNT_BITS-1:0]   feat_cnt_t;
    typedef logic [`HAR_SUM_BITS-1:0]   sum_t;
    typedef logic [`HAR_SCORE_BITS-1:0] score_t;
    typedef logic [`HAR_CLASS_BITS-1:0] class_idx_t;

    // ##############################
    // hidden layer weights
    // ##############################

    // bit f of an entry selects feature f.
    localparam logic [`HAR_FEAT_CNT-1:0] HIDDEN_POS_MASK [0:`HAR_HIDDEN_CNT-1] = '{
        12'hD42, 12'h32A, 12'h000, 12'h00C, 12'h1C8, 12'h000, 12'hA0C, 12'h946,
        12'h020, 12'hA23, 12'h308, 12'h08C, 12'hAF0, 12'h483, 12'h4C5, 12'h00A,
        12'h109, 12'h101, 12'hA28, 12'hD61, 12'hB10, 12'h0C0, 12'h420, 12'hC84,
        12'hAC8, 12'h25A, 12'h444, 12'h20A, 12'h0A0, 12'h059, 12'h109, 12'h10B,
        12'h006, 12'h0D2, 12'hC92, 12'h612, 12'h00A, 12'h0C0, 12'h110, 12'h489
    };

    localparam logic [`HAR_FEAT_CNT-1:0] HIDDEN_NEG_MASK [0:`HAR_HIDDEN_CNT-1] = '{
        12'h299, 12'h084, 12'h000, 12'hA31, 12'hE00, 12'h000, 12'h102, 12'h2B9,
        12'h40E, 12'h4CC, 12'h036, 12'hC00, 12'h001, 12'hA28, 12'h008, 12'hC21,
        12'hE00, 12'hA42, 12'h101, 12'h08E, 12'h402, 12'h208, 12'h390, 12'h211,
        12'h102, 12'h885, 12'h09A, 12'h050, 12'hB01, 12'h886, 12'h206, 12'h0F0,
        12'hE38, 12'h82D, 12'h049, 12'h941, 12'h431, 12'h225, 12'h801, 12'hB10
    };

    // neuron 2 is dead in the trained net. Neuron 5 has no weights and always fires.
    localparam logic [`HAR_HIDDEN_CNT-1:0] HIDDEN_FORCE_ZERO = 40'h00_0000_0004;

    // ##############################
    // output layer weights
    // ##############################

    localparam logic [`HAR_HIDDEN_CNT-1:0] CLASS_POS_MASK [0:`HAR_CLASS_CNT-1] = '{
        40'h04_0312_2440, 40'h04_0114_5440,
        40'h01_0b06_0442, 40'h05_8123_0011,
        40'h01_0000_5920, 40'h81_0c02_2809
    };

    // these hidden bits are counted when they are zero.
    localparam logic [`HAR_HIDDEN_CNT-1:0] CLASS_NEG_MASK [0:`HAR_CLASS_CNT-1] = '{
        40'h11_5441_4000, 40'h1a_a041_0820,
        40'h02_0460_2001, 40'h40_2004_0802,
        40'h48_a204_0010, 40'h48_2084_0000
    };

    localparam logic [2:0] CLASS_BIAS [0:`HAR_CLASS_CNT-1] = '{
        3'd1, 3'd0, 3'd2, 3'd3, 3'd4, 3'd3
    };

endpackage

`default_nettype wire

/* hw/har_tnn_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "har_tnn_params.svh"

module har_tnn_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic feat_valid,
    output logic shift_en,
    output logic hidden_en,
    output logic result_en,
    output logic busy,
    output logic pred_valid
);
    import har_tnn_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    feat_cnt_t   feat_cnt;
    logic        last_feat;

    // the result cycle still counts as busy, so no strobe is taken while LOAD is re-entered.
    assign busy      = (state != LOAD) || pred_valid;
    assign shift_en  = feat_valid && !busy;
    assign last_feat = shift_en && (feat_cnt == feat_cnt_t'(`HAR_FEAT_CNT - 1));
    assign hidden_en = (state == HIDDEN);
    assign result_en = (state == RESULT);

    always_comb begin
        state_next = state;
        case (state)
            LOAD:    if (last_feat) state_next = HIDDEN;
            HIDDEN:  state_next = RESULT;
            RESULT:  state_next = LOAD;
            default: state_next = LOAD;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= LOAD;
            feat_cnt   <= '0;
            pred_valid <= 1'b0;
        end else begin
            state      <= state_next;
            pred_valid <= result_en; // prediction register loads on the same edge.
            if (last_feat) begin
                feat_cnt <= '0;
            end else if (shift_en) begin
                feat_cnt <= feat_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/feature_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "har_tnn_params.svh"

module feature_buffer (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       shift_en,
    input  logic [`HAR_FEAT_BITS-1:0]                  feat_data,
    output logic [`HAR_FEAT_CNT*`HAR_FEAT_BITS-1:0]    features
);

    // new features enter at the top slot and move down one slot per strobe.
    // After twelve strobes the first one sits in slot 0.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            features <= '0;
        end else if (shift_en) begin
            features <= {feat_data, features[`HAR_FEAT_CNT*`HAR_FEAT_BITS-1:`HAR_FEAT_BITS]};
        end
    end

endmodule

`default_nettype wire

/* hw/tnn_hidden_layer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "har_tnn_params.svh"

module tnn_hidden_layer (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       hidden_en,
    input  logic [`HAR_FEAT_CNT*`HAR_FEAT_BITS-1:0]    features,
    output logic [`HAR_HIDDEN_CNT-1:0]                 hidden
);
    import har_tnn_pkg::*;

    sum_t                       pos_sum [0:`HAR_HIDDEN_CNT-1];
    sum_t                       neg_sum [0:`HAR_HIDDEN_CNT-1];
    logic [`HAR_HIDDEN_CNT-1:0] hidden_next;

    // a ternary neuron compares the +1 sum against the -1 sum.
    always_comb begin
        for (int n = 0; n < `HAR_HIDDEN_CNT; n++) begin
            pos_sum[n] = '0;
            neg_sum[n] = '0;
            for (int f = 0; f < `HAR_FEAT_CNT; f++) begin
                if (HIDDEN_POS_MASK[n][f]) begin
                    pos_sum[n] = pos_sum[n] + sum_t'(features[f*`HAR_FEAT_BITS +: `HAR_FEAT_BITS]);
                end
                if (HIDDEN_NEG_MASK[n][f]) begin
                    neg_sum[n] = neg_sum[n] + sum_t'(features[f*`HAR_FEAT_BITS +: `HAR_FEAT_BITS]);
                end
            end
            hidden_next[n] = (pos_sum[n] >= neg_sum[n]) && !HIDDEN_FORCE_ZERO[n];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hidden <= '0;
        end else if (hidden_en) begin
            hidden <= hidden_next;
        end
    end

endmodule

`default_nettype wire

/* hw/tnn_class_scorer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "har_tnn_params.svh"

module tnn_class_scorer (
    input  logic [`HAR_HIDDEN_CNT-1:0]                  hidden,
    output logic [`HAR_CLASS_CNT*`HAR_SCORE_BITS-1:0]   scores
);
    import har_tnn_pkg::*;

    logic [`HAR_HIDDEN_CNT-1:0] match [0:`HAR_CLASS_CNT-1];
    score_t                     hits  [0:`HAR_CLASS_CNT-1];

    // ##############################
    // popcount and bias per class
    // ##############################

    always_comb begin
        for (int c = 0; c < `HAR_CLASS_CNT; c++) begin
            // a +1 weight matches a set bit and a -1 weight matches a clear bit.
            match[c] = (hidden & CLASS_POS_MASK[c]) | (~hidden & CLASS_NEG_MASK[c]);
            hits[c]  = '0;
            for (int b = 0; b < `HAR_HIDDEN_CNT; b++) begin
                hits[c] = hits[c] + score_t'(match[c][b]);
            end
            scores[c*`HAR_SCORE_BITS +: `HAR_SCORE_BITS] =
                (hits[c] << 1) + score_t'(CLASS_BIAS[c]); // 2*hits maps matches to a +-1 sum.
        end
    end

endmodule

`default_nettype wire

/* hw/argmax_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "har_tnn_params.svh"

module argmax_select (
    input  logic [`HAR_CLASS_CNT*`HAR_SCORE_BITS-1:0] scores,
    output har_tnn_pkg::class_idx_t                   max_index
);
    import har_tnn_pkg::*;

    score_t     best_score;
    class_idx_t best_index;

    // only a strictly greater score replaces the leader, so ties keep the lower index.
    always_comb begin
        best_score = scores[0 +: `HAR_SCORE_BITS];
        best_index = '0;
        for (int c = 1; c < `HAR_CLASS_CNT; c++) begin
            if (scores[c*`HAR_SCORE_BITS +: `HAR_SCORE_BITS] > best_score) begin
                best_score = scores[c*`HAR_SCORE_BITS +: `HAR_SCORE_BITS];
                best_index = class_idx_t'(c);
            end
        end
    end

    assign max_index = best_index;

endmodule

`default_nettype wire

/* hw/har_tnn_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "har_tnn_params.svh"

module har_tnn_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        feat_valid,
    input  logic [`HAR_FEAT_BITS-1:0]   feat_data,
    output logic                        busy,
    output logic                        pred_valid,
    output logic [`HAR_CLASS_BITS-1:0]  prediction
);

    logic                                     shift_en;
    logic                                     hidden_en;
    logic                                     result_en;
    logic [`HAR_FEAT_CNT*`HAR_FEAT_BITS-1:0]  features;
    logic [`HAR_HIDDEN_CNT-1:0]               hidden;
    logic [`HAR_CLASS_CNT*`HAR_SCORE_BITS-1:0] scores;
    logic [`HAR_CLASS_BITS-1:0]               max_index;

    har_tnn_ctrl i_har_tnn_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .feat_valid (feat_valid),
        .shift_en   (shift_en),
        .hidden_en  (hidden_en),
        .result_en  (result_en),
        .busy       (busy),
        .pred_valid (pred_valid)
    );

    feature_buffer i_feature_buffer (
        .clk       (clk),
        .arst_n    (arst_n),
        .shift_en  (shift_en),
        .feat_data (feat_data),
        .features  (features)
    );

    tnn_hidden_layer i_tnn_hidden_layer (
        .clk       (clk),
        .arst_n    (arst_n),
        .hidden_en (hidden_en),
        .features  (features),
        .hidden    (hidden)
    );

    tnn_class_scorer i_tnn_class_scorer (
        .hidden (hidden),
        .scores (scores)
    );

    argmax_select i_argmax_select (
        .scores    (scores),
        .max_index (max_index)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prediction <= '0;
        end else if (result_en) begin
            prediction <= max_index; // held until the next sample finishes.
        end
    end

endmodule

`default_nettype wire

/* tests/har_tnn_props.sv */
`timescale 1ns/1ns
`default_nettype none

module har_tnn_props (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   hidden_en,
    input logic                   busy,
    input logic                   pred_valid,
    input har_tnn_pkg::feat_cnt_t feat_cnt
);

    pred_valid_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) pred_valid |=> !pred_valid
    ) else $error("pred_valid stayed high for more than one cycle.");

    // the result stage sits between hidden_en and pred_valid.
    pred_valid_after_hidden: assert property (
        @(posedge clk) disable iff (!arst_n) hidden_en |=> !pred_valid ##1 pred_valid
    ) else $error("pred_valid did not follow hidden_en by two edges.");

    busy_low_in_reset: assert property (
        @(posedge clk) !arst_n |-> !busy
    ) else $error("busy is high during reset.");

    // a strobe taken while busy would leave a nonzero count behind.
    no_shift_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n) busy |=> feat_cnt == '0
    ) else $error("a feature was counted while busy.");

endmodule

bind har_tnn_ctrl har_tnn_props i_har_tnn_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .hidden_en  (hidden_en),
    .busy       (busy),
    .pred_valid (pred_valid),
    .feat_cnt   (feat_cnt)
);

`default_nettype wire

/* tests/har_tnn_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "har_tnn_params.svh"

module har_tnn_tb;
    import har_tnn_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic                                    clk;
    logic                                    arst_n;
    logic                                    feat_valid;
    logic [`HAR_FEAT_BITS-1:0]               feat_data;
    logic                                    busy;
    logic                                    pred_valid;
    logic [`HAR_CLASS_BITS-1:0]              prediction;
    logic [`HAR_FEAT_CNT*`HAR_FEAT_BITS-1:0] sample;
    integer                                  seed;
    int                                      errors;
    int                                      checks;

    har_tnn_top i_har_tnn_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .feat_valid (feat_valid),
        .feat_data  (feat_data),
        .busy       (busy),
        .pred_valid (pred_valid),
        .prediction (prediction)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ##############################
    // reference model
    // ##############################

    function automatic int model_predict(input logic [`HAR_FEAT_CNT*`HAR_FEAT_BITS-1:0] feats);
        logic [`HAR_HIDDEN_CNT-1:0] hid;
        int pos;
        int neg;
        int hits;
        int score;
        int best_score;
        int best;
        for (int n = 0; n < `HAR_HIDDEN_CNT; n++) begin
            pos = 0;
            neg = 0;
            for (int f = 0; f < `HAR_FEAT_CNT; f++) begin
                if (HIDDEN_POS_MASK[n][f]) pos += int'(feats[f*`HAR_FEAT_BITS +: `HAR_FEAT_BITS]);
                if (HIDDEN_NEG_MASK[n][f]) neg += int'(feats[f*`HAR_FEAT_BITS +: `HAR_FEAT_BITS]);
            end
            hid[n] = (pos >= neg) && !HIDDEN_FORCE_ZERO[n];
        end
        best_score = -1;
        best = 0;
        for (int c = 0; c < `HAR_CLASS_CNT; c++) begin
            hits = 0;
            for (int b = 0; b < `HAR_HIDDEN_CNT; b++) begin
                if ((CLASS_POS_MASK[c][b] && hid[b]) || (CLASS_NEG_MASK[c][b] && !hid[b])) hits++;
            end
            score = 2 * hits + int'(CLASS_BIAS[c]);
            if (score > best_score) begin // strict compare keeps the lowest index on a tie.
                best_score = score;
                best = c;
            end
        end
        return best;
    endfunction

    // ##############################
    // driver and check tasks
    // ##############################

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic drive_feature(input logic [`HAR_FEAT_BITS-1:0] value);
        feat_valid = 1'b1;
        feat_data  = value;
        next_cycle();
        feat_valid = 1'b0;
    endtask

    task automatic random_sample;
        for (int i = 0; i < `HAR_FEAT_CNT; i++) begin
            sample[i*`HAR_FEAT_BITS +: `HAR_FEAT_BITS] = 4'($random(seed));
        end
    endtask

    task automatic wait_idle;
        int n;
        n = 0;
        while (busy && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (busy) begin
            errors++;
            $display("timeout: busy did not fall within %0d cycles", WAIT_LIMIT);
        end
    endtask

    // sends one sample and checks latency, busy and the predicted class.
    task automatic run_sample(input logic [`HAR_FEAT_CNT*`HAR_FEAT_BITS-1:0] feats,
                              input bit gapped, input bit junk);
        int edges;
        for (int i = 0; i < `HAR_FEAT_CNT; i++) begin
            if (gapped) repeat ($unsigned($random(seed)) % 4) next_cycle();
            drive_feature(feats[i*`HAR_FEAT_BITS +: `HAR_FEAT_BITS]);
        end
        edges = 0;
        while (!pred_valid && edges < WAIT_LIMIT) begin
            check_value("busy", busy, 1);
            if (junk) begin
                feat_valid = 1'b1; // these strobes arrive while busy and must be dropped.
                feat_data  = 4'($random(seed));
            end
            next_cycle();
            edges++;
        end
        if (!pred_valid) begin
            errors++;
            $display("timeout: no pred_valid within %0d cycles of the last feature", WAIT_LIMIT);
        end else begin
            check_value("busy", busy, 1);
            check_value("pred_valid latency", edges, 2);
            check_value("prediction", prediction, model_predict(feats));
        end
        if (junk) next_cycle();
        feat_valid = 1'b0;
        wait_idle();
    endtask

    task automatic report(input string name, input int errors_before);
        $display("test %-14s %s", name, (errors == errors_before) ? "ok" : "had errors");
    endtask

    // ##############################
    // directed tests
    // ##############################

    task automatic test_all_zero;
        int e0;
        e0 = errors;
        run_sample('0, 1'b0, 1'b0);
        report("all_zero", e0);
    endtask

    task automatic test_all_max;
        int e0;
        e0 = errors;
        run_sample({`HAR_FEAT_CNT{4'hF}}, 1'b0, 1'b0);
        report("all_max", e0);
    endtask

    task automatic test_random;
        int e0;
        e0 = errors;
        repeat (40) begin
            random_sample();
            run_sample(sample, 1'b0, 1'b0);
        end
        report("random", e0);
    endtask

    task automatic test_gapped_dropped;
        int e0;
        e0 = errors;
        repeat (4) begin
            random_sample();
            run_sample(sample, 1'b1, 1'b1);
        end
        report("gapped_dropped", e0);
    endtask

    task automatic test_reset_mid_load;
        int e0;
        e0 = errors;
        random_sample();
        for (int i = 0; i < `HAR_FEAT_CNT; i++) begin
            drive_feature(sample[i*`HAR_FEAT_BITS +: `HAR_FEAT_BITS]);
        end
        repeat (2) next_cycle();
        check_value("busy", busy, 1);
        check_value("pred_valid", pred_valid, 1);
        arst_n = 1'b0; // reset lands in the pred_valid cycle.
        #1;
        check_value("busy", busy, 0);
        check_value("pred_valid", pred_valid, 0);
        repeat (3) next_cycle();
        arst_n = 1'b1;
        random_sample();
        for (int i = 0; i < 5; i++) drive_feature(sample[i*`HAR_FEAT_BITS +: `HAR_FEAT_BITS]);
        arst_n = 1'b0;
        repeat (3) next_cycle();
        arst_n = 1'b1;
        random_sample();
        run_sample(sample, 1'b0, 1'b0); // count must have restarted at zero.
        report("reset_mid_load", e0);
    endtask

    initial begin
        seed       = 32'h1495_9bc6;
        errors     = 0;
        checks     = 0;
        sample     = '0;
        arst_n     = 1'b0;
        feat_valid = 1'b0;
        feat_data  = '0;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        test_all_zero();
        test_all_max();
        test_random();
        test_gapped_dropped();
        test_reset_mid_load();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hw
hw/har_tnn_pkg.sv
hw/har_tnn_ctrl.sv
hw/feature_buffer.sv
hw/tnn_hidden_layer.sv
hw/tnn_class_scorer.sv
hw/argmax_select.sv
hw/har_tnn_top.sv
tests/har_tnn_props.sv
tests/har_tnn_tb.sv

/* Makefile */
TOOL     := verilator
TOP      := har_tnn_tb
FILELIST := src.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
